//--- bench/mem_tile_sva.sv
`timescale 1ns/100ps
`include "tile_settings.svh"

module mem_tile_sva (
    input logic              qclk,
    input logic              rst_n,
    input logic              req_valid,
    input tile_pkg::t_opcode req_opcode,
    input tile_pkg::t_addr   req_address,
    input logic              rsp_valid,
    input logic              i_rsp_valid,
    input logic              d_rsp_valid
);
    import tile_pkg::*;

    t_region region;
    logic    mapped_rd;

    // Read that one of the two memories owns
    assign region    = req_address[`TILE_REGION_MSB:`TILE_REGION_LSB];
    assign mapped_rd = req_valid && (req_opcode == OP_RD) &&
                       ((region == t_region'(`TILE_I_REGION)) ||
                        (region == t_region'(`TILE_D_REGION)));

    // ======================================================================
    // Response timing
    // ======================================================================

    // Strobe held low in reset
    assert property (@(posedge qclk) !rst_n |-> !rsp_valid)
        else $error("rsp_valid high during reset");

    // One cycle after a mapped read
    assert property (@(posedge qclk) disable iff (!rst_n) mapped_rd |=> rsp_valid)
        else $error("rsp_valid missing one cycle after a mapped read");

    // And at no other time
    assert property (@(posedge qclk) disable iff (!rst_n) !mapped_rd |=> !rsp_valid)
        else $error("rsp_valid high without a mapped read");

    // Regions are disjoint
    assert property (@(posedge qclk) disable iff (!rst_n) !(i_rsp_valid && d_rsp_valid))
        else $error("both memories answered in the same cycle");

endmodule

bind mem_tile mem_tile_sva i_sva (
    .qclk        (qclk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req_opcode  (req_opcode),
    .req_address (req_address),
    .rsp_valid   (rsp_valid),
    .i_rsp_valid (i_rsp_valid),
    .d_rsp_valid (d_rsp_valid)
);

//--- bench/mem_tile_tb.sv
`timescale 1ns/100ps
`include "tile_settings.svh"

module mem_tile_tb;
    import tile_pkg::*;

    localparam int      RSP_TIMEOUT = 16;
    localparam int      WORDS       = 1 << (`TILE_I_MEM_MSB - 1);
    localparam t_region I_REG       = `TILE_I_REGION;
    localparam t_region D_REG       = `TILE_D_REGION;

    // DUT pins
    logic     qclk;
    logic     rst_n;
    t_addr    pc;
    logic     fetch_en;
    t_word    instruction;
    t_addr    d_addr;
    logic     d_rd_en;
    t_byte_en d_wr_be;
    t_word    d_wdata;
    t_word    d_rdata;
    logic     req_valid;
    t_opcode  req_opcode;
    t_addr    req_address;
    t_word    req_data;
    logic     rsp_valid;
    t_word    rsp_data;

    // Reference model with bank 0 for instruction and bank 1 for data
    t_word    model [0:1][0:WORDS-1];
    bit       known [0:1][0:WORDS-1];

    // Outstanding fabric reads in issue order
    t_word    exp_q [$];
    bit       known_q [$];
    int       issue_q [$];

    int       cycle;
    int       reads_issued;
    int       rsp_seen;
    int       value_errors;
    int       other_errors;

    mem_tile i_dut (
        .qclk        (qclk),
        .rst_n       (rst_n),
        .pc          (pc),
        .fetch_en    (fetch_en),
        .instruction (instruction),
        .d_addr      (d_addr),
        .d_rd_en     (d_rd_en),
        .d_wr_be     (d_wr_be),
        .d_wdata     (d_wdata),
        .d_rdata     (d_rdata),
        .req_valid   (req_valid),
        .req_opcode  (req_opcode),
        .req_address (req_address),
        .req_data    (req_data),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data)
    );

    initial begin
        qclk = 1'b0;
        forever #2 qclk = ~qclk;
    end

    // ======================================================================
    // Checks and model helpers
    // ======================================================================

    task automatic compare_word(string name, t_word got, t_word exp);
        assert (got === exp) else begin
            value_errors++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic expect_true(bit cond, string what);
        assert (cond) else begin
            other_errors++;
            $display("Failure at %0t: %s", $time, what);
        end
    endtask

    function automatic t_addr make_addr(t_region region, int idx);
        t_addr a;
        a = '0;
        a[`TILE_REGION_MSB:`TILE_REGION_LSB] = region;
        a[`TILE_I_MEM_MSB:2] = idx[`TILE_I_MEM_MSB-2:0];
        return a;
    endfunction

    function automatic int bank_of(t_region region);
        return (region == D_REG) ? 1 : 0;
    endfunction

    // Enabled lanes take the new byte
    function automatic t_word merge_bytes(t_word old_w, t_word new_w, t_byte_en be);
        t_word r;
        r = old_w;
        for (int b = 0; b < `TILE_BE_W; b++) begin
            if (be[b]) r[8*b +: 8] = new_w[8*b +: 8];
        end
        return r;
    endfunction

    // Response check at each falling edge
    task automatic collect_rsp();
        t_word exp;
        bit    was_known;
        int    issued;
        if (rsp_valid === 1'b1) begin
            rsp_seen++;
            if (exp_q.size() == 0) begin
                expect_true(1'b0, "fabric response with no read outstanding");
            end else begin
                exp       = exp_q.pop_front();
                was_known = known_q.pop_front();
                issued    = issue_q.pop_front();
                expect_true(cycle - issued == 1, "fabric response not one cycle after read");
                if (was_known) compare_word("rsp_data", rsp_data, exp);
            end
        end else if (rsp_valid !== 1'b0) begin
            expect_true(1'b0, "rsp_valid is unknown");
        end
    endtask

    task automatic next_cycle();
        @(negedge qclk);
        cycle++;
        collect_rsp();
    endtask

    task automatic drain_rsp();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < RSP_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            expect_true(1'b0, "timeout waiting for fabric read responses");
            exp_q.delete();
            known_q.delete();
            issue_q.delete();
        end
    endtask

    // ======================================================================
    // Bus drivers
    // ======================================================================

    // Raw request for one cycle without a model update
    task automatic send_request(t_opcode op, t_addr addr, t_word data);
        req_valid   = 1'b1;
        req_opcode  = op;
        req_address = addr;
        req_data    = data;
        next_cycle();
        req_valid   = 1'b0;
    endtask

    task automatic fabric_write(t_region region, int idx, t_word data);
        model[bank_of(region)][idx] = data;
        known[bank_of(region)][idx] = 1'b1;
        send_request(OP_WR, make_addr(region, idx), data);
    endtask

    task automatic fabric_read(t_region region, int idx);
        exp_q.push_back(model[bank_of(region)][idx]);
        known_q.push_back(known[bank_of(region)][idx]);
        issue_q.push_back(cycle);
        reads_issued++;
        send_request(OP_RD, make_addr(region, idx), $urandom);
    endtask

    task automatic core_store(int idx, t_byte_en be, t_word data);
        d_addr  = make_addr(D_REG, idx);
        d_wr_be = be;
        d_wdata = data;
        model[1][idx] = merge_bytes(model[1][idx], data, be);
        if (be == 4'hF) known[1][idx] = 1'b1;
        next_cycle();
        d_wr_be = '0;
    endtask

    task automatic core_load_check(int idx);
        d_addr  = make_addr(D_REG, idx);
        d_rd_en = 1'b1;
        next_cycle();
        d_rd_en = 1'b0;
        if (known[1][idx]) compare_word("d_rdata", d_rdata, model[1][idx]);
    endtask

    // Fetch on port A while the fabric reads on port B
    task automatic fetch_and_read(int fetch_idx, int read_idx);
        pc       = make_addr(I_REG, fetch_idx);
        fetch_en = 1'b1;
        fabric_read(I_REG, read_idx);
        fetch_en = 1'b0;
        compare_word("instruction", instruction, model[0][fetch_idx]);
        // Output holds with fetch_en low while pc moves
        pc = make_addr(I_REG, read_idx);
        next_cycle();
        compare_word("instruction", instruction, model[0][fetch_idx]);
    endtask

    // Same-edge core store and fabric write where the fabric wins
    task automatic store_collide(int idx, t_byte_en be, t_word core_w, t_word fab_w);
        d_addr  = make_addr(D_REG, idx);
        d_wr_be = be;
        d_wdata = core_w;
        fabric_write(D_REG, idx, fab_w);
        d_wr_be = '0;
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic idle_then_rw();
        for (int n = 0; n < 6; n++) next_cycle();
        expect_true(rsp_valid === 1'b0, "rsp_valid high after reset with no requests");
        for (int k = 0; k < 8; k++) begin
            fabric_write(I_REG, k, $urandom);
            fabric_write(D_REG, k, $urandom);
        end
        for (int k = 0; k < 8; k++) begin
            fabric_read(I_REG, k);
            fabric_read(D_REG, k);
        end
        drain_rsp();
    endtask

    task automatic fetch_beside_reads();
        for (int k = 16; k < 24; k++) fabric_write(I_REG, k, $urandom);
        for (int k = 0; k < 8; k++) fetch_and_read(16 + k, k);
        drain_rsp();
    endtask

    task automatic byte_merge();
        for (int k = 0; k < 6; k++) begin
            fabric_write(D_REG, 40 + k, $urandom);
            core_store(40 + k, t_byte_en'(k + 1), $urandom);
            core_store(40 + k, t_byte_en'(8 >> (k % 4)), $urandom);
            core_load_check(40 + k);
            fabric_read(D_REG, 40 + k);
        end
        drain_rsp();
    endtask

    task automatic unmapped_requests();
        t_region bad [4] = '{8'h02, 8'h10, 8'h80, 8'hFF};
        for (int k = 0; k < 4; k++) begin
            send_request(OP_WR, make_addr(bad[k], k), $urandom);
            send_request(OP_RD, make_addr(bad[k], k), $urandom);
            send_request(2'b00, make_addr(I_REG, k), $urandom);
            send_request(2'b11, make_addr(D_REG, k), $urandom);
        end
        // Both memories still hold the words from the first test
        for (int k = 0; k < 4; k++) begin
            fabric_read(I_REG, k);
            fabric_read(D_REG, k);
        end
        drain_rsp();
    endtask

    task automatic random_burst();
        t_region region;
        int      idx;
        int      reads_before;
        int      rsp_before;
        reads_before = reads_issued;
        rsp_before   = rsp_seen;
        for (int n = 0; n < 200; n++) begin
            region = ($urandom % 2 == 0) ? I_REG : D_REG;
            idx    = int'($urandom % 32);
            if ($urandom % 2 == 0) fabric_read(region, idx);
            else fabric_write(region, idx, $urandom);
        end
        drain_rsp();
        expect_true(rsp_seen - rsp_before == reads_issued - reads_before,
                    "response count differs from read count in burst");
    endtask

    task automatic collision_priority();
        for (int k = 0; k < 4; k++) begin
            store_collide(60 + k, t_byte_en'(4'hF >> k), $urandom, $urandom);
            core_load_check(60 + k);
            fabric_read(D_REG, 60 + k);
        end
        drain_rsp();
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        void'($urandom(64873));
        cycle        = 0;
        reads_issued = 0;
        rsp_seen     = 0;
        value_errors = 0;
        other_errors = 0;
        rst_n        = 1'b0;
        pc           = '0;
        fetch_en     = 1'b0;
        d_addr       = '0;
        d_rd_en      = 1'b0;
        d_wr_be      = '0;
        d_wdata      = '0;
        req_valid    = 1'b0;
        req_opcode   = '0;
        req_address  = '0;
        req_data     = '0;
        repeat (3) @(negedge qclk);
        rst_n = 1'b1;

        idle_then_rw();
        fetch_beside_reads();
        byte_merge();
        unmapped_requests();
        random_burst();
        collision_priority();

        $display("Value mismatches: %0d, other failures: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
design/tile_pkg.sv
design/fabric_req_if.sv
design/i_mem_wrap.sv
design/d_mem_wrap.sv
design/mem_tile.sv
bench/mem_tile_sva.sv
bench/mem_tile_tb.sv

//--- design/d_mem_wrap.sv
`timescale 1ns/100ps
`include "tile_settings.svh"

module d_mem_wrap (
    input  logic               qclk,
    input  logic               rst_n,
    // Core load/store port
    input  tile_pkg::t_addr    d_addr,
    input  logic               d_rd_en,
    input  tile_pkg::t_byte_en d_wr_be,
    input  tile_pkg::t_word    d_wdata,
    output tile_pkg::t_word    d_rdata,
    // Fabric port
    fabric_req_if.mem          req,
    output logic               rsp_valid,
    output tile_pkg::t_word    rsp_data
);
    import tile_pkg::*;

    // Word count from the top word-address bit
    localparam int unsigned D_WORDS = 2 ** (`TILE_D_MEM_MSB - 1);

    // Fabric decode
    t_region                   fab_region;
    logic                      fab_hit;
    logic                      fab_rd_en;
    logic                      fab_wr_en;

    // Word indices of both ports
    logic [`TILE_D_MEM_MSB:2]  fab_idx;
    logic [`TILE_D_MEM_MSB:2]  core_idx;

    // Same word hit by both writers this edge
    logic                      collide;
    // Core byte enables after fabric priority
    t_byte_en                  core_be;

    // Behavioural data array
    t_word                     mem [0:D_WORDS-1];

    // ======================================================================
    // Fabric request decode
    // ======================================================================

    assign fab_region = req.address[`TILE_REGION_MSB:`TILE_REGION_LSB];
    // Same decode as the instruction side, data region code
    assign fab_hit    = (fab_region == t_region'(`TILE_D_REGION));

    assign fab_rd_en  = req.valid && fab_hit && (req.opcode == OP_RD);
    assign fab_wr_en  = req.valid && fab_hit && (req.opcode == OP_WR);

    assign fab_idx    = req.address[`TILE_D_MEM_MSB:2];
    assign core_idx   = d_addr[`TILE_D_MEM_MSB:2];

    // ======================================================================
    // Write arbitration
    // ======================================================================

    // Fabric writes are full words
    // so a collision takes every byte from the fabric
    assign collide = fab_wr_en && (fab_idx == core_idx);
    assign core_be = collide ? '0 : d_wr_be;

    // ======================================================================
    // Memory array, both ports
    // ======================================================================

    // Core store per byte lane
    // fabric write after it, word wide
    always_ff @(posedge qclk) begin
        for (int b = 0; b < `TILE_BE_W; b++) begin
            if (core_be[b]) begin
                mem[core_idx][8*b +: 8] <= d_wdata[8*b +: 8];
            end
        end
        if (fab_wr_en) begin
            mem[fab_idx] <= req.data;
        end
    end

    // Core load
    // read-first, old word on a same-edge store
    always_ff @(posedge qclk) begin
        if (d_rd_en) begin
            d_rdata <= mem[core_idx];
        end
    end

    // Fabric read data, also read-first
    always_ff @(posedge qclk) begin
        if (fab_rd_en) begin
            rsp_data <= mem[fab_idx];
        end
    end

    // ======================================================================
    // Fabric response strobe
    // ======================================================================

    // High for one cycle per accepted read
    always_ff @(posedge qclk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= fab_rd_en;
        end
    end

endmodule

//--- design/fabric_req_if.sv
`timescale 1ns/100ps

interface fabric_req_if;
    import tile_pkg::*;

    // Request strobe, one request per cycle
    logic    valid;
    // OP_RD or OP_WR
    t_opcode opcode;
    // Byte address, region in top byte
    t_addr   address;
    // Write data, ignored on reads
    t_word   data;

    // Ring side
    modport src (
        output valid,
        output opcode,
        output address,
        output data
    );

    // Memory side, each memory decodes its own region
    modport mem (
        input valid,
        input opcode,
        input address,
        input data
    );

endinterface

//--- design/i_mem_wrap.sv
`timescale 1ns/100ps
`include "tile_settings.svh"

module i_mem_wrap (
    input  logic            qclk,
    input  logic            rst_n,
    // Core fetch port
    input  tile_pkg::t_addr pc,
    input  logic            fetch_en,
    output tile_pkg::t_word instruction,
    // Fabric port
    fabric_req_if.mem       req,
    output logic            rsp_valid,
    output tile_pkg::t_word rsp_data
);
    import tile_pkg::*;

    // Word count from the top word-address bit
    localparam int unsigned I_WORDS = 2 ** (`TILE_I_MEM_MSB - 1);

    // Fabric decode
    t_region                   fab_region;
    logic                      fab_hit;
    logic                      fab_rd_en;
    logic                      fab_wr_en;

    // Word indices of both ports
    logic [`TILE_I_MEM_MSB:2]  fab_idx;
    logic [`TILE_I_MEM_MSB:2]  fetch_idx;

    // Behavioural instruction array
    t_word                     mem [0:I_WORDS-1];

    // ======================================================================
    // Fabric request decode
    // ======================================================================

    assign fab_region = req.address[`TILE_REGION_MSB:`TILE_REGION_LSB];
    // Only our own region, other tiles answer the rest
    assign fab_hit    = (fab_region == t_region'(`TILE_I_REGION));

    assign fab_rd_en  = req.valid && fab_hit && (req.opcode == OP_RD);
    assign fab_wr_en  = req.valid && fab_hit && (req.opcode == OP_WR);

    // Byte offset dropped, word aligned
    assign fab_idx    = req.address[`TILE_I_MEM_MSB:2];
    assign fetch_idx  = pc[`TILE_I_MEM_MSB:2];

    // ======================================================================
    // Port B, fabric read/write
    // ======================================================================

    // Read-first
    // read data is the word before a same-edge write
    always_ff @(posedge qclk) begin
        if (fab_wr_en) begin
            mem[fab_idx] <= req.data;
        end
        if (fab_rd_en) begin
            rsp_data <= mem[fab_idx];
        end
    end

    // Response strobe one cycle after the read
    always_ff @(posedge qclk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= fab_rd_en;
        end
    end

    // ======================================================================
    // Port A, instruction fetch
    // ======================================================================

    // Registered fetch
    // instruction holds while fetch_en is low
    always_ff @(posedge qclk) begin
        if (fetch_en) begin
            instruction <= mem[fetch_idx];
        end
    end

endmodule

//--- design/mem_tile.sv
`timescale 1ns/100ps

module mem_tile (
    input  logic               qclk,
    input  logic               rst_n,
    // Instruction fetch
    input  tile_pkg::t_addr    pc,
    input  logic               fetch_en,
    output tile_pkg::t_word    instruction,
    // Data load/store
    input  tile_pkg::t_addr    d_addr,
    input  logic               d_rd_en,
    input  tile_pkg::t_byte_en d_wr_be,
    input  tile_pkg::t_word    d_wdata,
    output tile_pkg::t_word    d_rdata,
    // Fabric request
    input  logic               req_valid,
    input  tile_pkg::t_opcode  req_opcode,
    input  tile_pkg::t_addr    req_address,
    input  tile_pkg::t_word    req_data,
    // Fabric response
    output logic               rsp_valid,
    output tile_pkg::t_word    rsp_data
);
    import tile_pkg::*;

    // Per-memory responses
    logic  i_rsp_valid;
    t_word i_rsp_data;
    logic  d_rsp_valid;
    t_word d_rsp_data;

    // ======================================================================
    // Fabric request bundle
    // ======================================================================

    fabric_req_if req_if ();

    // Ring side of the bundle, straight from the pins
    // region decode stays in the memories
    assign req_if.valid   = req_valid;
    assign req_if.opcode  = req_opcode;
    assign req_if.address = req_address;
    assign req_if.data    = req_data;

    // ======================================================================
    // Memories
    // ======================================================================

    i_mem_wrap i_i_mem (
        .qclk        (qclk),
        .rst_n       (rst_n),
        .pc          (pc),
        .fetch_en    (fetch_en),
        .instruction (instruction),
        .req         (req_if.mem),
        .rsp_valid   (i_rsp_valid),
        .rsp_data    (i_rsp_data)
    );

    d_mem_wrap i_d_mem (
        .qclk      (qclk),
        .rst_n     (rst_n),
        .d_addr    (d_addr),
        .d_rd_en   (d_rd_en),
        .d_wr_be   (d_wr_be),
        .d_wdata   (d_wdata),
        .d_rdata   (d_rdata),
        .req       (req_if.mem),
        .rsp_valid (d_rsp_valid),
        .rsp_data  (d_rsp_data)
    );

    // ======================================================================
    // Response merge
    // ======================================================================

    // At most one region matches, so the strobes never overlap
    assign rsp_valid = i_rsp_valid | d_rsp_valid;
    // Data follows whichever memory answered
    assign rsp_data  = d_rsp_valid ? d_rsp_data : i_rsp_data;

endmodule

//--- design/tile_pkg.sv
`include "tile_settings.svh"

package tile_pkg;

    // ======================================================================
    // Datapath types
    // ======================================================================

    // Data word on core and fabric ports
    typedef logic [`TILE_WORD_W-1:0] t_word;

    // Byte address, region code in the top byte
    typedef logic [`TILE_ADDR_W-1:0] t_addr;

    // Region field of an address
    typedef logic [`TILE_REGION_MSB-`TILE_REGION_LSB:0] t_region;

    // One enable bit per byte lane
    typedef logic [`TILE_BE_W-1:0] t_byte_en;

    // ======================================================================
    // Fabric opcodes
    // ======================================================================

    typedef logic [`TILE_OPCODE_W-1:0] t_opcode;

    // Read, answered one cycle later
    localparam t_opcode OP_RD = 2'b01;

    // Write, silent
    localparam t_opcode OP_WR = 2'b10;

    // 2'b00 and 2'b11 are dropped by both memories

endpackage

//--- include/tile_settings.svh
`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// ==========================================================================
// Datapath widths
// ==========================================================================
`define TILE_WORD_W      32
`define TILE_ADDR_W      32
`define TILE_BE_W        (`TILE_WORD_W / 8)
`define TILE_OPCODE_W    2

// ==========================================================================
// Region decode
// ==========================================================================
// Top address byte picks the owning tile memory
`define TILE_REGION_MSB  31
`define TILE_REGION_LSB  24
`define TILE_I_REGION    8'h00
`define TILE_D_REGION    8'h01

// Top word-address bit, 4 KB per memory
`define TILE_I_MEM_MSB   11
`define TILE_D_MEM_MSB   11

`endif

//--- run.sh
#!/bin/sh
# Build and run the mem_tile testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module mem_tile_tb \
    > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vmem_tile_tb > sim.log 2>&1

grep -qx "No errors" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
